/* common/adam_defs.svh */
`ifndef ADAM_DEFS_SVH
`define ADAM_DEFS_SVH

// Bus widths
`define ADAM_ADDR_WIDTH 32
`define ADAM_DATA_WIDTH 32
`define ADAM_STRB_WIDTH (`ADAM_DATA_WIDTH / 8)

// Transactions in flight per bridge
`define ADAM_MAX_OUTSTANDING 4

`endif

/* common/adam_pkg.sv */
`default_nettype none

`include "adam_defs.svh"

package adam_pkg;

    typedef logic [`ADAM_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`ADAM_DATA_WIDTH-1:0] data_t;
    typedef logic [`ADAM_STRB_WIDTH-1:0] strb_t;

    // OKAY, EXOKAY, SLVERR, DECERR
    typedef logic [1:0] axil_resp_t;

    // Core side
    typedef struct packed {
        addr_t addr;
        logic  we;
        strb_t be;
        data_t wdata;
    } obi_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } obi_rsp_t;

    // AXI-Lite channel payloads
    typedef struct packed {
        addr_t addr;
    } axil_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axil_w_t;

    typedef struct packed {
        axil_resp_t resp;
    } axil_b_t;

    typedef struct packed {
        addr_t addr;
    } axil_ar_t;

    typedef struct packed {
        data_t      data;
        axil_resp_t resp;
    } axil_r_t;

    typedef enum logic [1:0] {
        RUN,
        DRAIN,
        PAUSED
    } bridge_state_t;

endpackage

`default_nettype wire

/* obi_to_axil/adam_obi_to_axil.sv */
`timescale 1ns/10ps
`default_nettype none

`include "adam_defs.svh"

module adam_obi_to_axil
    import adam_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     req_i,
    input  obi_req_t obi_i,
    output logic     gnt_o,
    output logic     rvalid_o,
    output obi_rsp_t rsp_o,

    input  logic     pause_req_i,
    output logic     pause_ack_o,

    output logic     awvalid_o,
    output axil_aw_t aw_o,
    input  logic     awready_i,

    output logic     wvalid_o,
    output axil_w_t  w_o,
    input  logic     wready_i,

    input  logic     bvalid_i,
    input  axil_b_t  b_i,
    output logic     bready_o,

    output logic     arvalid_o,
    output axil_ar_t ar_o,
    input  logic     arready_i,

    input  logic     rvalid_i,
    input  axil_r_t  r_i,
    output logic     rready_o
);

    localparam int DEPTH = `ADAM_MAX_OUTSTANDING;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    bridge_state_t state_q;

    logic aw_valid_q;
    logic w_valid_q;
    logic ar_valid_q;

    // Order record holds only the we bit of each outstanding access
    logic [DEPTH-1:0] order_we_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic     rvalid_q;
    obi_rsp_t rsp_q;

    logic full;
    logic empty;
    logic head_we;
    logic chan_free;
    logic push;
    logic b_hs;
    logic r_hs;
    logic pop;
    logic idle;

    assign full    = (count_q == CNT_W'(DEPTH));
    assign empty   = (count_q == '0);
    assign head_we = order_we_q[rd_ptr_q];

    assign chan_free = obi_i.we ? (!aw_valid_q && !w_valid_q) : !ar_valid_q;

    assign gnt_o = req_i && (state_q == RUN) && !pause_req_i && !full && chan_free;
    assign push  = gnt_o;

    // Only the channel of the oldest entry may hand back a response
    assign bready_o = !empty && head_we;
    assign rready_o = !empty && !head_we;

    assign b_hs = bvalid_i && bready_o;
    assign r_hs = rvalid_i && rready_o;
    assign pop  = b_hs || r_hs;

    assign idle = empty && !aw_valid_q && !w_valid_q && !ar_valid_q;

    assign awvalid_o = aw_valid_q;
    assign wvalid_o  = w_valid_q;
    assign arvalid_o = ar_valid_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
            ar_valid_q <= 1'b0;
        end else begin
            // AW and W drain independently of each other
            if (awready_i) begin
                aw_valid_q <= 1'b0;
            end
            if (wready_i) begin
                w_valid_q <= 1'b0;
            end
            if (arready_i) begin
                ar_valid_q <= 1'b0;
            end
            if (push && obi_i.we) begin
                aw_valid_q <= 1'b1;
                w_valid_q  <= 1'b1;
            end
            if (push && !obi_i.we) begin
                ar_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push && obi_i.we) begin
            aw_o.addr <= obi_i.addr;
            w_o.data  <= obi_i.wdata;
            w_o.strb  <= obi_i.be;
        end
        if (push && !obi_i.we) begin
            ar_o.addr <= obi_i.addr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            order_we_q[wr_ptr_q] <= obi_i.we;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= pop;
        end
    end

    // SLVERR and DECERR both have the upper bit set
    always_ff @(posedge clk_i) begin
        if (r_hs) begin
            rsp_q.rdata <= r_i.data;
            rsp_q.err   <= r_i.resp[1];
        end else if (b_hs) begin
            rsp_q.rdata <= '0;
            rsp_q.err   <= b_i.resp[1];
        end
    end

    assign rvalid_o = rvalid_q;
    assign rsp_o    = rsp_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RUN;
        end else begin
            case (state_q)
                RUN: begin
                    if (pause_req_i) begin
                        state_q <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (!pause_req_i) begin
                        state_q <= RUN;
                    end else if (idle) begin
                        state_q <= PAUSED;
                    end
                end
                PAUSED: begin
                    if (!pause_req_i) begin
                        state_q <= RUN;
                    end
                end
                default: state_q <= RUN;
            endcase
        end
    end

    assign pause_ack_o = (state_q == PAUSED);

endmodule

`default_nettype wire

/* hdl/adam_pause_demux.sv */
`timescale 1ns/10ps
`default_nettype none

module adam_pause_demux (
    input  logic clk_i,
    input  logic arst_n_i,

    input  logic pause_req_i,
    output logic pause_ack_o,

    output logic inst_req_o,
    input  logic inst_ack_i,

    output logic data_req_o,
    input  logic data_ack_i
);

    logic ack_q;
    logic all_ack;
    logic none_ack;

    // Both bridges are paused in parallel
    assign inst_req_o = pause_req_i;
    assign data_req_o = pause_req_i;

    assign all_ack  = inst_ack_i && data_ack_i;
    assign none_ack = !inst_ack_i && !data_ack_i;

    // Hold the outer ack until both bridges agree, whichever way
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else if (all_ack) begin
            ack_q <= 1'b1;
        end else if (none_ack) begin
            ack_q <= 1'b0;
        end
    end

    assign pause_ack_o = ack_q;

endmodule

`default_nettype wire

/* hdl/adam_core_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module adam_core_bridge
    import adam_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     pause_req_i,
    output logic     pause_ack_o,
    output logic     debug_unavail_o,

    // Instruction fetch port
    input  logic     inst_req_i,
    input  obi_req_t inst_obi_i,
    output logic     inst_gnt_o,
    output logic     inst_rvalid_o,
    output obi_rsp_t inst_rsp_o,

    // Load/store port
    input  logic     data_req_i,
    input  obi_req_t data_obi_i,
    output logic     data_gnt_o,
    output logic     data_rvalid_o,
    output obi_rsp_t data_rsp_o,

    output logic     inst_axil_awvalid_o,
    output axil_aw_t inst_axil_aw_o,
    input  logic     inst_axil_awready_i,
    output logic     inst_axil_wvalid_o,
    output axil_w_t  inst_axil_w_o,
    input  logic     inst_axil_wready_i,
    input  logic     inst_axil_bvalid_i,
    input  axil_b_t  inst_axil_b_i,
    output logic     inst_axil_bready_o,
    output logic     inst_axil_arvalid_o,
    output axil_ar_t inst_axil_ar_o,
    input  logic     inst_axil_arready_i,
    input  logic     inst_axil_rvalid_i,
    input  axil_r_t  inst_axil_r_i,
    output logic     inst_axil_rready_o,

    output logic     data_axil_awvalid_o,
    output axil_aw_t data_axil_aw_o,
    input  logic     data_axil_awready_i,
    output logic     data_axil_wvalid_o,
    output axil_w_t  data_axil_w_o,
    input  logic     data_axil_wready_i,
    input  logic     data_axil_bvalid_i,
    input  axil_b_t  data_axil_b_i,
    output logic     data_axil_bready_o,
    output logic     data_axil_arvalid_o,
    output axil_ar_t data_axil_ar_o,
    input  logic     data_axil_arready_i,
    input  logic     data_axil_rvalid_i,
    input  axil_r_t  data_axil_r_i,
    output logic     data_axil_rready_o
);

    logic inst_pause_req;
    logic inst_pause_ack;
    logic data_pause_req;
    logic data_pause_ack;

    // Debugger must keep off the core while it is being paused
    assign debug_unavail_o = pause_req_i || pause_ack_o;

    adam_obi_to_axil i_inst_bridge (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (inst_req_i),
        .obi_i       (inst_obi_i),
        .gnt_o       (inst_gnt_o),
        .rvalid_o    (inst_rvalid_o),
        .rsp_o       (inst_rsp_o),
        .pause_req_i (inst_pause_req),
        .pause_ack_o (inst_pause_ack),
        .awvalid_o   (inst_axil_awvalid_o),
        .aw_o        (inst_axil_aw_o),
        .awready_i   (inst_axil_awready_i),
        .wvalid_o    (inst_axil_wvalid_o),
        .w_o         (inst_axil_w_o),
        .wready_i    (inst_axil_wready_i),
        .bvalid_i    (inst_axil_bvalid_i),
        .b_i         (inst_axil_b_i),
        .bready_o    (inst_axil_bready_o),
        .arvalid_o   (inst_axil_arvalid_o),
        .ar_o        (inst_axil_ar_o),
        .arready_i   (inst_axil_arready_i),
        .rvalid_i    (inst_axil_rvalid_i),
        .r_i         (inst_axil_r_i),
        .rready_o    (inst_axil_rready_o)
    );

    adam_obi_to_axil i_data_bridge (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (data_req_i),
        .obi_i       (data_obi_i),
        .gnt_o       (data_gnt_o),
        .rvalid_o    (data_rvalid_o),
        .rsp_o       (data_rsp_o),
        .pause_req_i (data_pause_req),
        .pause_ack_o (data_pause_ack),
        .awvalid_o   (data_axil_awvalid_o),
        .aw_o        (data_axil_aw_o),
        .awready_i   (data_axil_awready_i),
        .wvalid_o    (data_axil_wvalid_o),
        .w_o         (data_axil_w_o),
        .wready_i    (data_axil_wready_i),
        .bvalid_i    (data_axil_bvalid_i),
        .b_i         (data_axil_b_i),
        .bready_o    (data_axil_bready_o),
        .arvalid_o   (data_axil_arvalid_o),
        .ar_o        (data_axil_ar_o),
        .arready_i   (data_axil_arready_i),
        .rvalid_i    (data_axil_rvalid_i),
        .r_i         (data_axil_r_i),
        .rready_o    (data_axil_rready_o)
    );

    adam_pause_demux i_pause_demux (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .pause_req_i (pause_req_i),
        .pause_ack_o (pause_ack_o),
        .inst_req_o  (inst_pause_req),
        .inst_ack_i  (inst_pause_ack),
        .data_req_o  (data_pause_req),
        .data_ack_i  (data_pause_ack)
    );

endmodule

`default_nettype wire

/* test/tb_axil_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_axil_mem
    import adam_pkg::*;
#(
    parameter int    WORDS       = 256,
    parameter int    STALL_ONE_IN = 4,
    parameter data_t FILL        = '0
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     awvalid_i,
    input  axil_aw_t aw_i,
    output logic     awready_o,
    input  logic     wvalid_i,
    input  axil_w_t  w_i,
    output logic     wready_o,
    output logic     bvalid_o,
    output axil_b_t  b_o,
    input  logic     bready_i,
    input  logic     arvalid_i,
    input  axil_ar_t ar_i,
    output logic     arready_o,
    output logic     rvalid_o,
    output axil_r_t  r_o,
    input  logic     rready_i
);

    data_t    mem [WORDS];
    logic     aw_have;
    logic     w_have;
    logic     b_have;
    logic     r_have;
    addr_t    aw_addr;
    axil_w_t  w_q;
    logic [2:0] go_q;

    // Fill depends on the whole word index
    initial begin
        for (int k = 0; k < WORDS; k++) begin
            mem[k] = FILL ^ (data_t'(k) * 32'h9E37_79B1);
        end
    end

    function automatic logic in_range(addr_t a);
        return {2'b00, a[31:2]} < 32'(WORDS);
    endfunction

    assign awready_o = !aw_have && go_q[0];
    assign wready_o  = !w_have && go_q[1];
    assign arready_o = !r_have && go_q[2];
    assign bvalid_o  = b_have;
    assign rvalid_o  = r_have;

    always @(posedge clk_i or negedge arst_n_i) begin
        int idx;
        if (!arst_n_i) begin
            aw_have <= 1'b0;
            w_have  <= 1'b0;
            b_have  <= 1'b0;
            r_have  <= 1'b0;
            go_q    <= '0;
            b_o     <= '0;
            r_o     <= '0;
        end else begin
            // Random ready stalls
            go_q[0] <= ($urandom % STALL_ONE_IN) != 0;
            go_q[1] <= ($urandom % STALL_ONE_IN) != 0;
            go_q[2] <= ($urandom % STALL_ONE_IN) != 0;
            if (awvalid_i && awready_o) begin
                aw_have <= 1'b1;
                aw_addr <= aw_i.addr;
            end
            if (wvalid_i && wready_o) begin
                w_have <= 1'b1;
                w_q    <= w_i;
            end
            if (aw_have && w_have && !b_have) begin
                b_have <= 1'b1;
                idx = 32'(aw_addr[31:2]);
                if (in_range(aw_addr)) begin
                    for (int i = 0; i < 4; i++) begin
                        if (w_q.strb[i]) begin
                            mem[idx][8*i +: 8] <= w_q.data[8*i +: 8];
                        end
                    end
                    b_o.resp <= 2'b00;
                end else begin
                    b_o.resp <= 2'b10;
                end
            end
            if (b_have && bready_i) begin
                b_have  <= 1'b0;
                aw_have <= 1'b0;
                w_have  <= 1'b0;
            end
            if (arvalid_i && arready_o) begin
                r_have <= 1'b1;
                idx = 32'(ar_i.addr[31:2]);
                if (in_range(ar_i.addr)) begin
                    r_o.data <= mem[idx];
                    r_o.resp <= 2'b00;
                end else begin
                    r_o.data <= '0;
                    r_o.resp <= 2'b10;
                end
            end
            if (r_have && rready_i) begin
                r_have <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_adam_core_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

`include "adam_defs.svh"

module tb_adam_core_bridge
    import adam_pkg::*;
;

    localparam int    PERIOD       = 10;
    localparam int    MEM_WORDS    = 256;
    localparam int    STALL_ONE_IN = 4;
    localparam int    SEED         = 7971;
    localparam int    STEPS        = 64;
    localparam data_t INST_FILL    = 32'h1357_9BDF;
    localparam data_t DATA_FILL    = 32'h2468_ACE0;

    logic clk_i;
    logic arst_n_i;
    logic pause_req_i;
    logic pause_ack_o;
    logic debug_unavail_o;
    logic inst_req_i;
    logic inst_gnt_o;
    logic inst_rvalid_o;
    logic data_req_i;
    logic data_gnt_o;
    logic data_rvalid_o;
    obi_req_t inst_obi_i;
    obi_req_t data_obi_i;
    obi_rsp_t inst_rsp_o;
    obi_rsp_t data_rsp_o;

    logic inst_axil_awvalid_o;
    logic inst_axil_wvalid_o;
    logic inst_axil_bready_o;
    logic inst_axil_arvalid_o;
    logic inst_axil_rready_o;
    logic inst_axil_awready_i;
    logic inst_axil_wready_i;
    logic inst_axil_bvalid_i;
    logic inst_axil_arready_i;
    logic inst_axil_rvalid_i;
    axil_aw_t inst_axil_aw_o;
    axil_w_t  inst_axil_w_o;
    axil_b_t  inst_axil_b_i;
    axil_ar_t inst_axil_ar_o;
    axil_r_t  inst_axil_r_i;

    logic data_axil_awvalid_o;
    logic data_axil_wvalid_o;
    logic data_axil_bready_o;
    logic data_axil_arvalid_o;
    logic data_axil_rready_o;
    logic data_axil_awready_i;
    logic data_axil_wready_i;
    logic data_axil_bvalid_i;
    logic data_axil_arready_i;
    logic data_axil_rvalid_i;
    axil_aw_t data_axil_aw_o;
    axil_w_t  data_axil_w_o;
    axil_b_t  data_axil_b_i;
    axil_ar_t data_axil_ar_o;
    axil_r_t  data_axil_r_i;

    obi_rsp_t inst_exp[$];
    obi_rsp_t data_exp[$];
    data_t    shadow [MEM_WORDS];
    int       errors;
    int       max_data_out;
    logic     pause_active;
    string    test_name;

    adam_core_bridge i_adam_core_bridge (.*);

    tb_axil_mem #(.WORDS(MEM_WORDS), .STALL_ONE_IN(STALL_ONE_IN), .FILL(INST_FILL)) i_inst_mem (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .awvalid_i(inst_axil_awvalid_o), .aw_i(inst_axil_aw_o), .awready_o(inst_axil_awready_i),
        .wvalid_i(inst_axil_wvalid_o), .w_i(inst_axil_w_o), .wready_o(inst_axil_wready_i),
        .bvalid_o(inst_axil_bvalid_i), .b_o(inst_axil_b_i), .bready_i(inst_axil_bready_o),
        .arvalid_i(inst_axil_arvalid_o), .ar_i(inst_axil_ar_o), .arready_o(inst_axil_arready_i),
        .rvalid_o(inst_axil_rvalid_i), .r_o(inst_axil_r_i), .rready_i(inst_axil_rready_o)
    );

    tb_axil_mem #(.WORDS(MEM_WORDS), .STALL_ONE_IN(STALL_ONE_IN), .FILL(DATA_FILL)) i_data_mem (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .awvalid_i(data_axil_awvalid_o), .aw_i(data_axil_aw_o), .awready_o(data_axil_awready_i),
        .wvalid_i(data_axil_wvalid_o), .w_i(data_axil_w_o), .wready_o(data_axil_wready_i),
        .bvalid_o(data_axil_bvalid_i), .b_o(data_axil_b_i), .bready_i(data_axil_bready_o),
        .arvalid_i(data_axil_arvalid_o), .ar_i(data_axil_ar_o), .arready_o(data_axil_arready_i),
        .rvalid_o(data_axil_rvalid_i), .r_o(data_axil_r_i), .rready_i(data_axil_rready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = !clk_i;
    end

    initial begin
        #(STEPS * 200 * PERIOD);
        $display("Timeout: the tests did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    function automatic data_t fill_word(data_t pat, int k);
        return pat ^ (data_t'(k) * 32'h9E37_79B1);
    endfunction

    function automatic data_t merge(data_t old, data_t wd, strb_t be);
        data_t r;
        r = old;
        for (int i = 0; i < `ADAM_STRB_WIDTH; i++) begin
            if (be[i]) begin
                r[8*i +: 8] = wd[8*i +: 8];
            end
        end
        return r;
    endfunction

    function automatic logic in_range(addr_t a);
        return {2'b00, a[31:2]} < 32'(MEM_WORDS);
    endfunction

    task automatic compare_rsp(string name, obi_rsp_t exp, obi_rsp_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected rdata=%h err=%b, actual rdata=%h err=%b",
                     name, exp.rdata, exp.err, act.rdata, act.err);
            errors++;
        end
    endtask

    task automatic compare_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_count(string name, int exp, int act);
        if (exp != act) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // Response checker and pause rules, every cycle
    always @(posedge clk_i) begin
        if (arst_n_i) begin
            if (inst_rvalid_o) begin
                if (inst_exp.size() == 0) begin
                    $display("Unexpected instruction response in %s", test_name);
                    errors++;
                end else begin
                    compare_rsp({test_name, " inst"}, inst_exp.pop_front(), inst_rsp_o);
                end
            end
            if (data_rvalid_o) begin
                if (data_exp.size() == 0) begin
                    $display("Unexpected data response in %s", test_name);
                    errors++;
                end else begin
                    compare_rsp({test_name, " data"}, data_exp.pop_front(), data_rsp_o);
                end
            end
            if (pause_req_i && (inst_gnt_o || data_gnt_o)) begin
                $display("A request was granted while a pause was requested");
                errors++;
            end
            if (pause_ack_o && (inst_exp.size() + data_exp.size()) != 0) begin
                $display("Pause acknowledged while responses were still outstanding");
                errors++;
            end
            compare_bit({test_name, " debug_unavail"}, pause_active, debug_unavail_o);
        end
    end

    // Deepest data record, sampled once pushes and pops have settled
    always @(negedge clk_i) begin
        if (data_exp.size() > max_data_out) begin
            max_data_out = data_exp.size();
        end
    end

    task automatic issue(logic on_inst, obi_req_t r, obi_rsp_t exp);
        @(negedge clk_i);
        if (on_inst) begin
            inst_req_i = 1'b1;
            inst_obi_i = r;
            data_req_i = 1'b0;
        end else begin
            data_req_i = 1'b1;
            data_obi_i = r;
            inst_req_i = 1'b0;
        end
        @(posedge clk_i);
        while (!(on_inst ? inst_gnt_o : data_gnt_o)) begin
            @(posedge clk_i);
        end
        if (on_inst) begin
            inst_exp.push_back(exp);
        end else begin
            data_exp.push_back(exp);
        end
    endtask

    task automatic drop_requests();
        @(negedge clk_i);
        inst_req_i = 1'b0;
        data_req_i = 1'b0;
    endtask

    task automatic wait_idle();
        drop_requests();
        while (inst_exp.size() != 0 || data_exp.size() != 0) @(posedge clk_i);
        @(negedge clk_i);
    endtask

    task automatic access(logic on_inst, addr_t addr, logic we, data_t wd, strb_t be);
        obi_req_t r;
        obi_rsp_t exp;
        int idx;
        idx = 32'(addr[31:2]);
        r.addr  = addr;
        r.we    = we;
        r.be    = be;
        r.wdata = wd;
        exp.err   = !in_range(addr);
        exp.rdata = '0;
        if (we && in_range(addr)) begin
            shadow[idx] = merge(shadow[idx], wd, be);
        end else if (!we && in_range(addr)) begin
            exp.rdata = on_inst ? fill_word(INST_FILL, idx) : shadow[idx];
        end
        issue(on_inst, r, exp);
    endtask

    task automatic fetch_test();
        test_name = "fetch";
        for (int k = 0; k < 8; k++) begin
            access(1'b1, addr_t'(k * 4), 1'b0, '0, '1);
        end
        wait_idle();
    endtask

    task automatic write_read_test();
        test_name = "write_read";
        for (int k = 16; k < 24; k++) begin
            access(1'b0, addr_t'(k * 4), 1'b1, $urandom, strb_t'($urandom % 16));
        end
        wait_idle();
        for (int k = 16; k < 24; k++) begin
            access(1'b0, addr_t'(k * 4), 1'b0, '0, '1);
        end
        wait_idle();
    endtask

    // Writes and reads use disjoint words so memory order cannot matter
    task automatic pipeline_test();
        test_name = "pipeline";
        max_data_out = 0;
        for (int i = 0; i < 24; i++) begin
            if ($urandom % 2 != 0) begin
                access(1'b0, addr_t'((32 + $urandom % 32) * 4), 1'b1, $urandom,
                       strb_t'($urandom % 16));
            end else begin
                access(1'b0, addr_t'(($urandom % 32) * 4), 1'b0, '0, '1);
            end
        end
        wait_idle();
        compare_bit("pipeline depth of two or more", 1'b1, max_data_out >= 2);
    endtask

    task automatic pause_test();
        test_name = "pause";
        access(1'b1, addr_t'(40), 1'b0, '0, '1);
        access(1'b0, addr_t'(96 * 4), 1'b1, $urandom, 4'hF);
        access(1'b0, addr_t'(97 * 4), 1'b1, $urandom, 4'h3);
        access(1'b0, addr_t'(8), 1'b0, '0, '1);
        @(negedge clk_i);
        pause_req_i  = 1'b1;
        pause_active = 1'b1;
        // Read held during the pause must not be granted
        data_obi_i.addr = addr_t'(12);
        data_obi_i.we   = 1'b0;
        while (!pause_ack_o) @(posedge clk_i);
        compare_count("outstanding at pause ack", 0, inst_exp.size() + data_exp.size());
        repeat (5) @(posedge clk_i);
        drop_requests();
        pause_req_i = 1'b0;
        // Bridges release one cycle after the request, the demux one cycle later
        @(negedge clk_i);
        compare_bit("pause ack one cycle after release", 1'b1, pause_ack_o);
        @(negedge clk_i);
        compare_bit("pause ack two cycles after release", 1'b0, pause_ack_o);
        pause_active = 1'b0;
        access(1'b0, addr_t'(12), 1'b0, '0, '1);
        access(1'b1, addr_t'(44), 1'b0, '0, '1);
        wait_idle();
    endtask

    task automatic error_test();
        test_name = "error";
        access(1'b0, addr_t'(32'h0000_1000), 1'b0, '0, '1);
        access(1'b0, addr_t'(32'h0000_2004), 1'b1, $urandom, 4'hF);
        access(1'b1, addr_t'(MEM_WORDS * 4), 1'b0, '0, '1);
        access(1'b1, addr_t'(MEM_WORDS * 4 + 8), 1'b1, $urandom, 4'hF);
        wait_idle();
    endtask

    initial begin
        void'($urandom(SEED));
        errors       = 0;
        max_data_out = 0;
        pause_active = 1'b0;
        test_name    = "reset";
        arst_n_i     = 1'b0;
        pause_req_i  = 1'b0;
        inst_req_i   = 1'b0;
        data_req_i   = 1'b0;
        inst_obi_i   = '0;
        data_obi_i   = '0;
        for (int k = 0; k < MEM_WORDS; k++) begin
            shadow[k] = fill_word(DATA_FILL, k);
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        compare_bit("reset inst gnt", 1'b0, inst_gnt_o);
        compare_bit("reset data gnt", 1'b0, data_gnt_o);
        compare_bit("reset inst rvalid", 1'b0, inst_rvalid_o);
        compare_bit("reset data rvalid", 1'b0, data_rvalid_o);
        compare_bit("reset pause_ack", 1'b0, pause_ack_o);
        compare_bit("reset debug_unavail", 1'b0, debug_unavail_o);
        compare_bit("reset inst awvalid", 1'b0, inst_axil_awvalid_o);
        compare_bit("reset inst wvalid", 1'b0, inst_axil_wvalid_o);
        compare_bit("reset inst arvalid", 1'b0, inst_axil_arvalid_o);
        compare_bit("reset inst bready", 1'b0, inst_axil_bready_o);
        compare_bit("reset inst rready", 1'b0, inst_axil_rready_o);
        compare_bit("reset data awvalid", 1'b0, data_axil_awvalid_o);
        compare_bit("reset data wvalid", 1'b0, data_axil_wvalid_o);
        compare_bit("reset data arvalid", 1'b0, data_axil_arvalid_o);
        compare_bit("reset data bready", 1'b0, data_axil_bready_o);
        compare_bit("reset data rready", 1'b0, data_axil_rready_o);
        fetch_test();
        write_read_test();
        pipeline_test();
        pause_test();
        error_test();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/adam_pkg.sv
obi_to_axil/adam_obi_to_axil.sv
hdl/adam_pause_demux.sv
hdl/adam_core_bridge.sv
test/tb_axil_mem.sv
test/tb_adam_core_bridge.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_adam_core_bridge -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0
